/* rom_fetch.f */
source/rom_pkg.sv
source/rom_slot.sv
source/rom_arbiter.sv
source/rom_download.sv
source/rom_fetch.sv
sim/tb_clk.sv
sim/sdram_model.sv
sim/rom_fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= rom_fetch_tb
FILELIST  ?= rom_fetch.f
OBJ_DIR   ?= obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim/rom_fetch_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module rom_fetch_tb;
    import rom_pkg::*;

    localparam int          GFX_AW      = 18;
    localparam int          SND_AW      = 15;
    localparam int          MAIN_AW     = 18;
    localparam sdram_addr_t GFX_OFFSET  = 22'h02_4000;
    localparam sdram_addr_t SND_OFFSET  = 22'h02_0000;
    localparam sdram_addr_t MAIN_OFFSET = 22'h00_0000;
    localparam ioctl_addr_t PROM_START  = 25'h0C_8000;
    localparam int          DL_N        = 14;
    localparam int          RD_N        = 10;
    localparam int          CYCLE_NS    = 20;
    localparam int          LIMIT_NS    = (DL_N + RD_N + 3) * 40 * CYCLE_NS + 10 * CYCLE_NS;

    typedef struct packed {
        ioctl_addr_t addr;
        byte_t       data;
    } dl_entry_t;

    typedef struct packed {
        logic [1:0]  slot;  // 0 gfx, 1 sound, 2 main
        logic [17:0] addr;
        logic        hit;   // Expected cache hit
    } rd_entry_t;

    logic         clk;
    logic         rst_n;
    logic         downloading;
    ioctl_addr_t  ioctl_addr;
    byte_t        ioctl_dout;
    logic         ioctl_wr;
    logic         gfx_cs, snd_cs, main_cs;
    logic [GFX_AW-1:0]  gfx_addr;
    logic [SND_AW-1:0]  snd_addr;
    logic [MAIN_AW-1:0] main_addr;
    word_t        gfx_data;
    byte_t        snd_data, main_data;
    logic         gfx_ok, snd_ok, main_ok;
    logic         sdram_req, sdram_ack, data_rdy;
    sdram_addr_t  sdram_addr;
    word_t        data_read;
    prog_t        prog;
    logic         prom_we;

    dl_entry_t    dl_tab [DL_N];
    rd_entry_t    rd_tab [RD_N];
    word_t        ref_mem [sdram_addr_t];
    int           errors;
    int           tests;

    tb_clk #(.PERIOD_NS(CYCLE_NS), .RST_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

    rom_fetch #(
        .GFX_AW(GFX_AW), .SND_AW(SND_AW), .MAIN_AW(MAIN_AW),
        .GFX_OFFSET(GFX_OFFSET), .SND_OFFSET(SND_OFFSET), .MAIN_OFFSET(MAIN_OFFSET),
        .PROM_START(PROM_START)
    ) rom_fetch_inst (
        .clk(clk), .rst_n(rst_n),
        .downloading(downloading), .ioctl_addr(ioctl_addr),
        .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .gfx_cs(gfx_cs), .gfx_addr(gfx_addr), .gfx_data(gfx_data), .gfx_ok(gfx_ok),
        .snd_cs(snd_cs), .snd_addr(snd_addr), .snd_data(snd_data), .snd_ok(snd_ok),
        .main_cs(main_cs), .main_addr(main_addr), .main_data(main_data), .main_ok(main_ok),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read),
        .prog(prog), .prom_we(prom_we)
    );

    sdram_model u_sdram (
        .clk(clk), .rst_n(rst_n), .downloading(downloading), .prog(prog),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read)
    );

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input sdram_addr_t got,
                              input sdram_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "wrong");
    endtask

    function automatic word_t ref_word(input sdram_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return word_t'(a) ^ 16'h5a5a;
    endfunction

    // Expected SDRAM contents after the download
    task automatic build_reference();
        sdram_addr_t wa;
        for (int i = 0; i < DL_N; i++) begin
            if (dl_tab[i].addr < PROM_START) begin
                wa = sdram_addr_t'(dl_tab[i].addr >> 1);
                ref_mem[wa] = ref_word(wa);
                if (dl_tab[i].addr[0]) ref_mem[wa][15:8] = dl_tab[i].data;
                else                   ref_mem[wa][7:0]  = dl_tab[i].data;
            end
        end
    endtask

    function automatic word_t expect_gfx(input logic [17:0] a);
        return ref_word(GFX_OFFSET + sdram_addr_t'(a));
    endfunction

    function automatic byte_t expect_byte(input sdram_addr_t offset, input logic [17:0] a);
        word_t w;
        w = ref_word(offset + sdram_addr_t'(a >> 1));
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic load_tables();
        dl_tab[0]  = '{25'h000000, 8'h11};    // Main CPU region
        dl_tab[1]  = '{25'h000001, 8'h22};
        dl_tab[2]  = '{25'h000002, 8'h33};
        dl_tab[3]  = '{25'h000003, 8'h44};
        dl_tab[4]  = '{25'h040000, 8'h55};    // Sound region
        dl_tab[5]  = '{25'h040001, 8'h66};
        dl_tab[6]  = '{25'h040010, 8'h77};    // Low lane only
        dl_tab[7]  = '{25'h048000, 8'h88};    // Graphics region
        dl_tab[8]  = '{25'h048001, 8'h99};
        dl_tab[9]  = '{25'h048002, 8'haa};
        dl_tab[10] = '{25'h048003, 8'hbb};
        dl_tab[11] = '{25'h0C8000, 8'hcc};    // PROM
        dl_tab[12] = '{25'h0C8005, 8'hdd};
        dl_tab[13] = '{25'h048005, 8'hee};
        rd_tab[0] = '{2'd0, 18'h00000, 1'b0};
        rd_tab[1] = '{2'd0, 18'h00000, 1'b1};
        rd_tab[2] = '{2'd0, 18'h00001, 1'b0};
        rd_tab[3] = '{2'd1, 18'h00000, 1'b0};
        rd_tab[4] = '{2'd1, 18'h00001, 1'b1};
        rd_tab[5] = '{2'd1, 18'h00011, 1'b0};
        rd_tab[6] = '{2'd2, 18'h00003, 1'b0};
        rd_tab[7] = '{2'd2, 18'h00002, 1'b1};
        rd_tab[8] = '{2'd2, 18'h00100, 1'b0};
        rd_tab[9] = '{2'd0, 18'h00100, 1'b0};
    endtask

    task automatic download_byte(input ioctl_addr_t a, input byte_t d);
        int n;
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_dout <= d;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(negedge clk);
        check_addr("prog.addr", prog.addr, sdram_addr_t'(a >> 1));
        check_byte("prog.data", prog.data, d);
        if (a < PROM_START) begin
            check_bit("prog.we", prog.we, 1'b1);
            check_bit("prom_we", prom_we, 1'b0);
            check_mask("prog.mask", prog.mask, a[0] ? 2'b01 : 2'b10);
            n = 0;
            while (prog.we && n < 20) begin
                @(negedge clk);
                n++;
            end
            if (prog.we) begin
                $display("SDRAM write at %h was never acknowledged", a);
                errors++;
            end
        end else begin
            check_bit("prom_we", prom_we, 1'b1);
            check_bit("prog.we", prog.we, 1'b0);
            @(negedge clk);
            check_bit("prom_we", prom_we, 1'b0);    // One cycle only
        end
        repeat ($urandom_range(4, 1)) @(posedge clk);
    endtask

    task automatic read_slot(input logic [1:0] slot, input logic [17:0] a, input bit hit);
        int   waited;
        int   req_cycles;
        logic ok_now;
        @(posedge clk);
        case (slot)
            2'd0: begin
                gfx_cs   <= 1'b1;
                gfx_addr <= a;
            end
            2'd1: begin
                snd_cs   <= 1'b1;
                snd_addr <= a[SND_AW-1:0];
            end
            default: begin
                main_cs   <= 1'b1;
                main_addr <= a;
            end
        endcase
        waited     = 0;
        req_cycles = 0;
        forever begin
            @(negedge clk);
            ok_now = (slot == 2'd0) ? gfx_ok : (slot == 2'd1) ? snd_ok : main_ok;
            if (sdram_req) req_cycles++;
            if (ok_now || waited >= 40) break;
            waited++;
        end
        if (!ok_now) begin
            $display("Slot %0d never returned ok for address %h", slot, a);
            errors++;
        end else begin
            if (hit) begin
                check_bit("hit_in_same_cycle", waited == 0, 1'b1);
            end
            case (slot)
                2'd0: check_word("gfx_data", gfx_data, expect_gfx(a));
                2'd1: check_byte("snd_data", snd_data, expect_byte(SND_OFFSET, a));
                default: check_byte("main_data", main_data, expect_byte(MAIN_OFFSET, a));
            endcase
        end
        @(posedge clk);
        gfx_cs  <= 1'b0;
        snd_cs  <= 1'b0;
        main_cs <= 1'b0;
        // A late request from the hit shows up one cycle after ok
        @(negedge clk);
        if (sdram_req) req_cycles++;
        if (hit) begin
            check_bit("sdram_req", req_cycles != 0, 1'b0);
        end
    endtask

    task automatic contention();
        sdram_addr_t seen [$];
        logic [2:0]  got_ok;
        logic        prev_req;
        int          n;
        @(posedge clk);
        gfx_cs    <= 1'b1;
        gfx_addr  <= 18'h00001;
        snd_cs    <= 1'b1;
        snd_addr  <= 15'h0000;
        main_cs   <= 1'b1;
        main_addr <= 18'h00000;
        got_ok   = '0;
        prev_req = 1'b0;
        n        = 0;
        while (got_ok != 3'b111 && n < 80) begin
            @(negedge clk);
            if (sdram_req && !prev_req) seen.push_back(sdram_addr);
            prev_req = sdram_req;
            got_ok   = got_ok | {main_ok, snd_ok, gfx_ok};
            n++;
        end
        if (got_ok != 3'b111) begin
            $display("Not all slots answered under contention, ok seen %b", got_ok);
            errors++;
        end
        check_word("gfx_data", gfx_data, expect_gfx(18'h00001));
        check_byte("snd_data", snd_data, expect_byte(SND_OFFSET, 18'h00000));
        check_byte("main_data", main_data, expect_byte(MAIN_OFFSET, 18'h00000));
        if (seen.size() != 3) begin
            $display("Expected 3 SDRAM reads under contention, saw %0d", seen.size());
            errors++;
        end else begin
            check_addr("sdram_addr[0]", seen[0], GFX_OFFSET + 22'd1);
            check_addr("sdram_addr[1]", seen[1], SND_OFFSET);
            check_addr("sdram_addr[2]", seen[2], MAIN_OFFSET);
        end
        @(posedge clk);
        gfx_cs  <= 1'b0;
        snd_cs  <= 1'b0;
        main_cs <= 1'b0;
    endtask

    // Watchdog
    initial begin
        #(LIMIT_NS);
        $display("Run stopped by the watchdog after %0d ns", LIMIT_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int err_before;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        gfx_cs      = 1'b0;
        snd_cs      = 1'b0;
        main_cs     = 1'b0;
        gfx_addr    = '0;
        snd_addr    = '0;
        main_addr   = '0;
        errors      = 0;
        tests       = 0;
        void'($urandom(32'hc7e2b476));  // Seeds the gaps between loader bytes
        load_tables();
        build_reference();

        @(posedge rst_n);
        @(negedge clk);
        err_before = errors;
        check_bit("sdram_req", sdram_req, 1'b0);
        check_bit("prog.we", prog.we, 1'b0);
        check_bit("prom_we", prom_we, 1'b0);
        check_bit("gfx_ok", gfx_ok, 1'b0);
        check_bit("snd_ok", snd_ok, 1'b0);
        check_bit("main_ok", main_ok, 1'b0);
        report("reset", err_before);

        @(posedge clk);
        downloading <= 1'b1;
        for (int i = 0; i < DL_N; i++) begin
            err_before = errors;
            download_byte(dl_tab[i].addr, dl_tab[i].data);
            report((dl_tab[i].addr < PROM_START) ? "download" : "prom", err_before);
        end
        @(posedge clk);
        downloading <= 1'b0;

        for (int i = 0; i < RD_N; i++) begin
            err_before = errors;
            read_slot(rd_tab[i].slot, rd_tab[i].addr, rd_tab[i].hit);
            report(rd_tab[i].hit ? "read hit" : "read miss", err_before);
        end

        err_before = errors;
        contention();
        report("contention", err_before);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/sdram_model.sv */
`default_nettype none
`timescale 1ns/1ps

module sdram_model (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       downloading,
    input  wire rom_pkg::prog_t       prog,
    input  wire                       sdram_req,
    input  wire rom_pkg::sdram_addr_t sdram_addr,
    output logic                      sdram_ack,
    output logic                      data_rdy,
    output rom_pkg::word_t            data_read
);
    import rom_pkg::*;

    word_t       mem [sdram_addr_t];    // Only written words are stored
    sdram_addr_t rd_addr;
    logic        busy;
    logic [1:0]  cnt;

    // Untouched words read as a pattern of their own address
    function automatic word_t read_word(input sdram_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return word_t'(a) ^ 16'h5a5a;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            busy      <= 1'b0;
            cnt       <= '0;
            rd_addr   <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (busy) begin
                if (cnt == 2'd0) begin
                    data_rdy  <= 1'b1;
                    data_read <= read_word(rd_addr);
                    busy      <= 1'b0;
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end else if (sdram_ack) begin
                // Requester drops its strobe in the cycle after ack
            end else if (downloading && prog.we) begin
                mem[sdram_addr] = read_word(sdram_addr);
                if (!prog.mask[0]) mem[sdram_addr][7:0] = prog.data;
                if (!prog.mask[1]) mem[sdram_addr][15:8] = prog.data;
                sdram_ack <= 1'b1;
            end else if (sdram_req) begin
                sdram_ack <= 1'b1;
                busy      <= 1'b1;
                rd_addr   <= sdram_addr;
                cnt       <= 2'd2;      // data_rdy three cycles after ack
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_clk.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clk #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low for a few clocks
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* source/rom_fetch.sv */
`default_nettype none
`timescale 1ns/1ps

module rom_fetch #(
    parameter int                   GFX_AW      = 18,
    parameter int                   SND_AW      = 15,
    parameter int                   MAIN_AW     = 18,
    parameter rom_pkg::sdram_addr_t GFX_OFFSET  = 22'h02_4000,
    parameter rom_pkg::sdram_addr_t SND_OFFSET  = 22'h02_0000,
    parameter rom_pkg::sdram_addr_t MAIN_OFFSET = 22'h00_0000,
    parameter rom_pkg::ioctl_addr_t PROM_START  = 25'h0C_8000
) (
    input  wire                       clk,
    input  wire                       rst_n,
    // Loader
    input  wire                       downloading,
    input  wire rom_pkg::ioctl_addr_t ioctl_addr,
    input  wire rom_pkg::byte_t       ioctl_dout,
    input  wire                       ioctl_wr,
    // Graphics slot addresses whole words
    input  wire                       gfx_cs,
    input  wire [GFX_AW-1:0]          gfx_addr,
    output rom_pkg::word_t            gfx_data,
    output logic                      gfx_ok,
    // Sound CPU
    input  wire                       snd_cs,
    input  wire [SND_AW-1:0]          snd_addr,
    output rom_pkg::byte_t            snd_data,
    output logic                      snd_ok,
    // Main CPU
    input  wire                       main_cs,
    input  wire [MAIN_AW-1:0]         main_addr,
    output rom_pkg::byte_t            main_data,
    output logic                      main_ok,
    // SDRAM
    output logic                      sdram_req,
    output rom_pkg::sdram_addr_t      sdram_addr,
    input  wire                       sdram_ack,
    input  wire                       data_rdy,
    input  wire rom_pkg::word_t       data_read,
    // Program port
    output rom_pkg::prog_t            prog,
    output logic                      prom_we
);
    import rom_pkg::*;

    slot_req_t [NSLOT-1:0] slot_req;    // 0 gfx, 1 sound, 2 main
    logic      [NSLOT-1:0] slot_done;
    word_t                 rd_data;
    sdram_addr_t           arb_addr;

    // Downloader owns the address bus while loading
    assign sdram_addr = downloading ? prog.addr : arb_addr;

    rom_download #(.PROM_START(PROM_START)) u_dwnld (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog        ),
        .prom_we     ( prom_we     )
    );

    rom_slot #(.data_t(word_t), .AW(GFX_AW), .OFFSET(GFX_OFFSET)) u_gfx (
        .clk     ( clk          ),
        .rst_n   ( rst_n        ),
        .cs      ( gfx_cs       ),
        .addr    ( gfx_addr     ),
        .done    ( slot_done[0] ),
        .rd_data ( rd_data      ),
        .data    ( gfx_data     ),
        .ok      ( gfx_ok       ),
        .req     ( slot_req[0]  )
    );

    rom_slot #(.data_t(byte_t), .AW(SND_AW), .OFFSET(SND_OFFSET)) u_snd (
        .clk     ( clk          ),
        .rst_n   ( rst_n        ),
        .cs      ( snd_cs       ),
        .addr    ( snd_addr     ),
        .done    ( slot_done[1] ),
        .rd_data ( rd_data      ),
        .data    ( snd_data     ),
        .ok      ( snd_ok       ),
        .req     ( slot_req[1]  )
    );

    rom_slot #(.data_t(byte_t), .AW(MAIN_AW), .OFFSET(MAIN_OFFSET)) u_main (
        .clk     ( clk          ),
        .rst_n   ( rst_n        ),
        .cs      ( main_cs      ),
        .addr    ( main_addr    ),
        .done    ( slot_done[2] ),
        .rd_data ( rd_data      ),
        .data    ( main_data    ),
        .ok      ( main_ok      ),
        .req     ( slot_req[2]  )
    );

    rom_arbiter u_arb (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .req         ( slot_req    ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .done        ( slot_done   ),
        .rd_data     ( rd_data     ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( arb_addr    )
    );

endmodule

`default_nettype wire

/* source/rom_download.sv */
`default_nettype none
`timescale 1ns/1ps

module rom_download #(
    parameter rom_pkg::ioctl_addr_t PROM_START = 25'h0C_8000
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       downloading,
    input  wire rom_pkg::ioctl_addr_t ioctl_addr,
    input  wire rom_pkg::byte_t       ioctl_dout,
    input  wire                       ioctl_wr,
    input  wire                       sdram_ack,
    output rom_pkg::prog_t            prog,
    output logic                      prom_we
);
    import rom_pkg::*;

    sdram_addr_t wr_addr;
    byte_t       wr_data;
    logic [1:0]  wr_mask;
    logic        wr_we;
    logic        take;      // Byte accepted this cycle
    logic        is_prom;

    // Bytes arriving while a write is still open are dropped
    assign take    = downloading && ioctl_wr && !wr_we;
    assign is_prom = ioctl_addr >= PROM_START;

    always_ff @(posedge clk) begin
        if (take) begin
            wr_addr <= ioctl_addr[SDRAM_AW:1];          // Byte to word address
            wr_data <= ioctl_dout;
            wr_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Odd byte goes high
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_we   <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= take && is_prom;     // Single cycle strobe
            if (take && !is_prom) begin
                wr_we <= 1'b1;
            end else if (sdram_ack) begin
                wr_we <= 1'b0;
            end
        end
    end

    assign prog = '{addr: wr_addr, data: wr_data, mask: wr_mask, we: wr_we};

    a_we_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(prog.we && prom_we)
    );

endmodule

`default_nettype wire

/* source/rom_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module rom_arbiter (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire                                          downloading,
    input  wire rom_pkg::slot_req_t [rom_pkg::NSLOT-1:0] req,
    input  wire                                          sdram_ack,
    input  wire                                          data_rdy,
    input  wire rom_pkg::word_t                          data_read,
    output logic [rom_pkg::NSLOT-1:0]                    done,
    output rom_pkg::word_t                               rd_data,
    output logic                                         sdram_req,
    output rom_pkg::sdram_addr_t                         sdram_addr
);
    import rom_pkg::*;

    localparam int IDX_W = $clog2(NSLOT);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,     // sdram_req held until ack
        ST_WAIT     // Waiting for data_rdy
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] winner;
    logic [IDX_W-1:0] pick;
    logic             found;
    logic             start;

    // Lowest index wins, so the loop runs from the top down
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = NSLOT - 1; i >= 0; i--) begin
            if (req[i].pending) begin
                pick  = IDX_W'(i);
                found = 1'b1;
            end
        end
    end

    assign start = (state == ST_IDLE) && found && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            winner <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state  <= ST_REQ;
                        winner <= pick;
                    end
                end
                ST_REQ: begin
                    if (downloading) begin
                        state <= ST_IDLE;   // Slot stays pending and retries
                    end else if (sdram_ack) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= req[pick].addr;
        end
    end

    assign sdram_req = (state == ST_REQ) && !downloading;
    assign rd_data   = data_read;   // Valid while done is high

    always_comb begin
        done = '0;
        if ((state == ST_WAIT) && data_rdy) begin
            done[winner] = 1'b1;
        end
    end

    a_no_read_in_dwnld: assert property (
        @(posedge clk) disable iff (!rst_n) downloading |-> !sdram_req
    );

    a_single_done: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(done)
    );

endmodule

`default_nettype wire

/* source/rom_slot.sv */
`default_nettype none
`timescale 1ns/1ps

module rom_slot #(
    parameter type                  data_t = rom_pkg::word_t,
    parameter int                   AW     = 18,
    parameter rom_pkg::sdram_addr_t OFFSET = '0
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     cs,
    input  wire [AW-1:0]            addr,
    input  wire                     done,
    input  wire rom_pkg::word_t     rd_data,
    output data_t                   data,
    output logic                    ok,
    output rom_pkg::slot_req_t      req
);
    import rom_pkg::*;

    // Byte wide clients address bytes, word wide ones address words
    localparam bit BYTE_SLOT = $bits(data_t) == 8;

    sdram_addr_t word_addr;     // SDRAM word for the current client address
    sdram_addr_t cache_addr;
    word_t       cache_data;
    logic        cache_valid;
    logic        hit;

    generate
        if (BYTE_SLOT) begin : g_byte_addr
            assign word_addr = OFFSET + sdram_addr_t'(addr >> 1);
        end else begin : g_word_addr
            assign word_addr = OFFSET + sdram_addr_t'(addr);
        end
    endgenerate

    assign hit = cache_valid && (cache_addr == word_addr);
    assign ok  = cs && hit;     // Hit shows in the same cycle

    // Pending drops as soon as the arbiter hands back the word
    assign req.pending = cs && !hit && !done;
    assign req.addr    = word_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_valid <= 1'b0;
        end else if (done) begin
            cache_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            cache_data <= rd_data;
            cache_addr <= word_addr;    // Client holds its address until ok
        end
    end

    // Address bit 0 picks the upper byte
    generate
        if (BYTE_SLOT) begin : g_byte_data
            assign data = data_t'(addr[0] ? cache_data[15:8] : cache_data[7:0]);
        end else begin : g_word_data
            assign data = data_t'(cache_data);
        end
    endgenerate

    a_ok_needs_cs: assert property (
        @(posedge clk) disable iff (!rst_n) !cs |-> !ok
    );

    // The arbiter only answers a slot that is still missing
    a_done_on_miss: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> (cs && !hit)
    );

endmodule

`default_nettype wire

/* source/rom_pkg.sv */
`default_nettype none

package rom_pkg;

    localparam int SDRAM_AW = 22;   // SDRAM word address
    localparam int IOCTL_AW = 25;   // Loader byte address
    localparam int NSLOT    = 3;    // Read clients on the arbiter

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [15:0]         word_t;
    typedef logic [7:0]          byte_t;
    typedef logic [IOCTL_AW-1:0] ioctl_addr_t;

    // Read request from a slot to the arbiter
    typedef struct packed {
        logic        pending;
        sdram_addr_t addr;
    } slot_req_t;

    // Download write port towards the SDRAM controller
    typedef struct packed {
        sdram_addr_t addr;
        byte_t       data;
        logic [1:0]  mask;  // Active low byte enables
        logic        we;
    } prog_t;

endpackage

`default_nettype wire
